// ==== hw/lsu_agu.sv ====
// Stage 1 of the load/store unit
// Forms the address, byte enables and misalignment exception of an issued op
// and holds it in the control register until stage 2 takes it

module lsu_agu
  import lsu_cfg_pkg::*;
  import lsu_types_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // Issue port
  input  logic      lsu_valid_i,
  input  lsu_req_t  lsu_req_i,
  output logic      lsu_ready_o,
  // Link to stage 2
  input  logic      take_i,
  output lsu_ctrl_t ctrl_o
);

  logic [XLEN-1:0]    vaddr;
  logic [BE_BITS-1:0] be;
  logic               is_store;
  logic               misaligned;
  exception_t         mis_ex;
  logic               accept;
  lsu_ctrl_t          ctrl_d;
  lsu_ctrl_t          ctrl_q;

  // --------------------
  // Address generation
  // --------------------
  // No translation, so this is also the physical address
  assign vaddr = $unsigned($signed(lsu_req_i.operand_a) + $signed(lsu_req_i.imm));

  // --------------------
  // Byte enables and alignment
  // --------------------
  always_comb begin
    be         = '0;
    misaligned = 1'b0;
    is_store   = 1'b0;
    unique case (lsu_req_i.operation)
      LB, LBU: begin
        be = BE_BITS'(1) << vaddr[1:0];
      end
      SB: begin
        be       = BE_BITS'(1) << vaddr[1:0];
        is_store = 1'b1;
      end
      LH, LHU: begin
        be         = BE_BITS'(3) << vaddr[1:0];
        misaligned = vaddr[0];
      end
      SH: begin
        be         = BE_BITS'(3) << vaddr[1:0];
        misaligned = vaddr[0];
        is_store   = 1'b1;
      end
      LW: begin
        be         = '1;
        misaligned = (vaddr[1:0] != 2'b00);
      end
      SW: begin
        be         = '1;
        misaligned = (vaddr[1:0] != 2'b00);
        is_store   = 1'b1;
      end
    endcase
  end

  // Misaligned ops carry the faulting address as tval
  always_comb begin
    mis_ex = '0;
    if (misaligned) begin
      mis_ex.valid = 1'b1;
      mis_ex.cause = is_store ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
      mis_ex.tval  = vaddr;
    end
  end

  // Next contents of the control register
  always_comb begin
    ctrl_d.valid     = lsu_valid_i;
    ctrl_d.vaddr     = vaddr;
    ctrl_d.be        = be;
    ctrl_d.operation = lsu_req_i.operation;
    ctrl_d.store     = is_store;
    ctrl_d.data      = lsu_req_i.data;
    ctrl_d.trans_id  = lsu_req_i.trans_id;
    ctrl_d.ex        = mis_ex;
  end

  // --------------------
  // Control register
  // --------------------
  // Free when empty or when its op leaves in this cycle
  assign lsu_ready_o = ~ctrl_q.valid | take_i;
  assign accept      = lsu_valid_i & lsu_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= '0;
    end else if (accept) begin
      ctrl_q <= ctrl_d;
    end else if (take_i) begin
      ctrl_q.valid <= 1'b0;
    end
  end

  assign ctrl_o = ctrl_q;

endmodule

// ==== hw/lsu_cfg_pkg.sv ====
// Configuration constants of the load/store unit
// Widths, result pipe depths and exception cause codes

package lsu_cfg_pkg;

  // --------------------
  // Widths
  // --------------------
  // Data and address width
  localparam int unsigned XLEN          = 32;
  // Width of the transaction tag carried with each op
  localparam int unsigned TRANS_ID_BITS = 3;
  // One enable bit per byte lane
  localparam int unsigned BE_BITS       = XLEN / 8;

  // --------------------
  // Result pipes
  // --------------------
  // Output register stages on each result path, 0 gives a pass-through
  localparam int unsigned LOAD_PIPE_REGS  = 1;
  localparam int unsigned STORE_PIPE_REGS = 1;

  // --------------------
  // Exception causes
  // --------------------
  localparam logic [7:0] CAUSE_LD_MISALIGNED = 8'd4;
  localparam logic [7:0] CAUSE_ST_MISALIGNED = 8'd6;

endpackage

// ==== hw/lsu_mem_access.sv ====
// Stage 2 of the load/store unit
// Issues memory requests, waits for load data and forms the load and store results

module lsu_mem_access
  import lsu_cfg_pkg::*;
  import lsu_types_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  // Link to stage 1
  input  lsu_ctrl_t       ctrl_i,
  output logic            take_o,
  // Data memory port
  output mem_req_t        mem_req_o,
  input  logic            mem_rvalid_i,
  input  logic [XLEN-1:0] mem_rdata_i,
  // Results
  output lsu_result_t     ld_res_o,
  output lsu_result_t     st_res_o
);

  logic                     take;
  logic                     issue_ld;
  logic                     waiting_q;
  lsu_op_e                  ld_op_q;
  logic [1:0]               ld_off_q;
  logic [TRANS_ID_BITS-1:0] ld_id_q;
  logic [XLEN-1:0]          rdata_shifted;
  logic [XLEN-1:0]          ld_data;

  // An outstanding load blocks the next op
  assign take     = ctrl_i.valid & ~waiting_q;
  assign take_o   = take;
  // Aligned loads go to memory, misaligned ones answer at once
  assign issue_ld = take & ~ctrl_i.store & ~ctrl_i.ex.valid;

  // --------------------
  // Memory request
  // --------------------
  always_comb begin
    mem_req_o.req   = take & ~ctrl_i.ex.valid;
    mem_req_o.we    = ctrl_i.store;
    mem_req_o.addr  = ctrl_i.vaddr;
    mem_req_o.be    = ctrl_i.be;
    // Store data moves up into the lanes picked by the low address bits
    mem_req_o.wdata = ctrl_i.data << {ctrl_i.vaddr[1:0], 3'b000};
  end

  // --------------------
  // Outstanding load
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      waiting_q <= 1'b0;
    end else if (issue_ld) begin
      waiting_q <= 1'b1;
    end else if (mem_rvalid_i) begin
      waiting_q <= 1'b0;
    end
  end

  // What is needed to shape the returning data
  always_ff @(posedge clk_i) begin
    if (issue_ld) begin
      ld_op_q  <= ctrl_i.operation;
      ld_off_q <= ctrl_i.vaddr[1:0];
      ld_id_q  <= ctrl_i.trans_id;
    end
  end

  // --------------------
  // Load data extension
  // --------------------
  // Addressed byte or half word moves down to lane 0
  assign rdata_shifted = mem_rdata_i >> {ld_off_q, 3'b000};

  always_comb begin
    unique case (ld_op_q)
      LB:      ld_data = {{(XLEN - 8){rdata_shifted[7]}}, rdata_shifted[7:0]};
      LBU:     ld_data = {{(XLEN - 8){1'b0}}, rdata_shifted[7:0]};
      LH:      ld_data = {{(XLEN - 16){rdata_shifted[15]}}, rdata_shifted[15:0]};
      LHU:     ld_data = {{(XLEN - 16){1'b0}}, rdata_shifted[15:0]};
      default: ld_data = rdata_shifted;
    endcase
  end

  // --------------------
  // Results
  // --------------------
  // Loads finish either at once with an exception or when data returns
  always_comb begin
    ld_res_o = '0;
    if (take && !ctrl_i.store && ctrl_i.ex.valid) begin
      ld_res_o.valid    = 1'b1;
      ld_res_o.trans_id = ctrl_i.trans_id;
      ld_res_o.ex       = ctrl_i.ex;
    end else if (waiting_q && mem_rvalid_i) begin
      ld_res_o.valid    = 1'b1;
      ld_res_o.trans_id = ld_id_q;
      ld_res_o.result   = ld_data;
    end
  end

  // Stores finish in the cycle they are taken
  always_comb begin
    st_res_o          = '0;
    st_res_o.valid    = take & ctrl_i.store;
    st_res_o.trans_id = ctrl_i.trans_id;
    st_res_o.ex       = ctrl_i.ex;
  end

endmodule

// ==== hw/lsu_result_pipe.sv ====
// Output pipeline for one result path
// Delays a payload by DEPTH register stages or passes it through when DEPTH is 0

module lsu_result_pipe #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t d_i,
  output payload_t d_o
);

  if (DEPTH == 0) begin : gen_bypass
    assign d_o = d_i;
  end else begin : gen_regs
    payload_t stage_q [DEPTH];

    // Each stage takes the payload of the stage before it
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        for (int i = 0; i < DEPTH; i++) begin
          stage_q[i] <= '0;
        end
      end else begin
        stage_q[0] <= d_i;
        for (int i = 1; i < DEPTH; i++) begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end

    assign d_o = stage_q[DEPTH-1];
  end

endmodule

// ==== hw/lsu_top.sv ====
// Load/store unit top level
// Address stage, memory access stage and the load and store result pipes

module lsu_top
  import lsu_cfg_pkg::*;
  import lsu_types_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  // Issue port
  input  logic            lsu_valid_i,
  input  lsu_req_t        lsu_req_i,
  output logic            lsu_ready_o,
  // Data memory port
  output mem_req_t        mem_req_o,
  input  logic            mem_rvalid_i,
  input  logic [XLEN-1:0] mem_rdata_i,
  // Results
  output lsu_result_t     load_res_o,
  output lsu_result_t     store_res_o
);

  lsu_ctrl_t   ctrl;
  logic        take;
  lsu_result_t ld_res;
  lsu_result_t st_res;

  // --------------------
  // Stage 1
  // --------------------
  lsu_agu u_agu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lsu_valid_i (lsu_valid_i),
    .lsu_req_i   (lsu_req_i),
    .lsu_ready_o (lsu_ready_o),
    .take_i      (take),
    .ctrl_o      (ctrl)
  );

  // --------------------
  // Stage 2
  // --------------------
  lsu_mem_access u_mem_access (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ctrl_i       (ctrl),
    .take_o       (take),
    .mem_req_o    (mem_req_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .ld_res_o     (ld_res),
    .st_res_o     (st_res)
  );

  // --------------------
  // Result pipes
  // --------------------
  lsu_result_pipe #(
    .payload_t (lsu_result_t),
    .DEPTH     (LOAD_PIPE_REGS)
  ) u_load_pipe (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (ld_res),
    .d_o    (load_res_o)
  );

  lsu_result_pipe #(
    .payload_t (lsu_result_t),
    .DEPTH     (STORE_PIPE_REGS)
  ) u_store_pipe (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (st_res),
    .d_o    (store_res_o)
  );

endmodule

// ==== hw/lsu_types_pkg.sv ====
// Types shared by the stages of the load/store unit
// Operation encoding and the packed structs passed between stages

package lsu_types_pkg;
  import lsu_cfg_pkg::*;

  // Supported load and store operations
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LBU = 3'd1,
    LH  = 3'd2,
    LHU = 3'd3,
    LW  = 3'd4,
    SB  = 3'd5,
    SH  = 3'd6,
    SW  = 3'd7
  } lsu_op_e;

  // Exception reported with a result
  typedef struct packed {
    logic            valid;
    logic [7:0]      cause;
    logic [XLEN-1:0] tval;
  } exception_t;

  // --------------------
  // Issue side
  // --------------------
  typedef struct packed {
    lsu_op_e                  operation;
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          imm;
    logic [XLEN-1:0]          data;
    logic [TRANS_ID_BITS-1:0] trans_id;
  } lsu_req_t;

  // Stage-1 control register
  typedef struct packed {
    logic                     valid;
    logic [XLEN-1:0]          vaddr;
    logic [BE_BITS-1:0]       be;
    lsu_op_e                  operation;
    logic                     store;
    logic [XLEN-1:0]          data;
    logic [TRANS_ID_BITS-1:0] trans_id;
    exception_t               ex;
  } lsu_ctrl_t;

  // --------------------
  // Memory side
  // --------------------
  typedef struct packed {
    logic               req;
    logic               we;
    logic [XLEN-1:0]    addr;
    logic [BE_BITS-1:0] be;
    logic [XLEN-1:0]    wdata;
  } mem_req_t;

  // Load or store result, one valid cycle per op
  typedef struct packed {
    logic                     valid;
    logic [TRANS_ID_BITS-1:0] trans_id;
    logic [XLEN-1:0]          result;
    exception_t               ex;
  } lsu_result_t;

endpackage

// ==== sim.f ====
hw/lsu_cfg_pkg.sv
hw/lsu_types_pkg.sv
hw/lsu_agu.sv
hw/lsu_mem_access.sv
hw/lsu_result_pipe.sv
hw/lsu_top.sv
verification/tb_lsu_mem.sv
verification/tb_lsu.sv

// ==== verification/tb_lsu.sv ====
// Testbench for the load/store unit
// Issues stores, loads and misaligned ops and checks every output with assertions

module tb_lsu
  import lsu_types_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_OPS = 16 + 7 + 26 + 12 + 40;
  localparam int LIMIT = 20 * N_OPS + 100;

  typedef struct {
    lsu_result_t res;
    logic        is_load;
    int          due;
    string       name;
  } expect_t;

  logic        clk_i;
  logic        rst_ni;
  logic        lsu_valid_i;
  lsu_req_t    lsu_req_i;
  logic        lsu_ready_o;
  mem_req_t    mem_req_o;
  logic        mem_rvalid_i;
  logic [31:0] mem_rdata_i;
  lsu_result_t load_res_o;
  lsu_result_t store_res_o;

  logic [31:0] shadow [16];
  expect_t     exp_q [$];
  mem_req_t    mreq_q [$];
  string       mreq_name_q [$];
  int          cyc;
  int          err_val;
  int          err_other;
  integer      seed;
  logic [2:0]  next_id;
  // Expectations for what is on the outputs in the current cycle
  logic        have_res;
  logic        exp_is_load;
  logic        on_time;
  lsu_result_t exp_res;
  string       exp_name;
  logic        have_mreq;
  mem_req_t    exp_mreq;
  string       mreq_name;
  // Occupancy model sampled once per cycle
  logic        acc_s;
  logic        ldreq_s;
  logic        rv_s;
  logic        ld_out;
  logic        s1_full;

  lsu_top u_lsu_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lsu_valid_i  (lsu_valid_i),
    .lsu_req_i    (lsu_req_i),
    .lsu_ready_o  (lsu_ready_o),
    .mem_req_o    (mem_req_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .load_res_o   (load_res_o),
    .store_res_o  (store_res_o)
  );

  tb_lsu_mem u_mem (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mem_req_i    (mem_req_o),
    .mem_rvalid_o (mem_rvalid_i),
    .mem_rdata_o  (mem_rdata_i)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc == LIMIT) begin
      $display("Timeout after %0d cycles, %0d results still missing", LIMIT, exp_q.size());
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lane_mask(input logic [3:0] be);
    logic [31:0] m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    return m;
  endfunction

  function automatic logic [31:0] extend(input lsu_op_e op, input logic [31:0] v);
    case (op)
      LB:      return {{24{v[7]}}, v[7:0]};
      LBU:     return {24'h0, v[7:0]};
      LH:      return {{16{v[15]}}, v[15:0]};
      LHU:     return {16'h0, v[15:0]};
      default: return v;
    endcase
  endfunction

  // Expected request and result of an op at the cycle it is accepted
  task automatic predict(input string name, input lsu_req_t req);
    expect_t     e;
    mem_req_t    m;
    logic [31:0] addr;
    logic [31:0] word;
    logic [3:0]  be;
    int          off;
    int          n;
    logic        st;
    logic        free;
    addr = req.operand_a + req.imm;
    off  = int'(addr[1:0]);
    st   = req.operation inside {SB, SH, SW};
    if (req.operation inside {LB, LBU, SB}) begin
      n = 1;
    end else if (req.operation inside {LH, LHU, SH}) begin
      n = 2;
    end else begin
      n = 4;
    end
    be   = 4'((1 << n) - 1) << off;
    // Stage 2 is free next cycle unless a load waits for its data
    free = !((ld_out && !mem_rvalid_i) || (mem_req_o.req && !mem_req_o.we));
    e.name         = $sformatf("%s %s", name, req.operation.name());
    e.is_load      = !st;
    e.res          = '0;
    e.res.valid    = 1'b1;
    e.res.trans_id = req.trans_id;
    e.due          = 0;
    if ((st || (off % n) != 0) && free) begin
      e.due = cyc + 3;
    end
    if ((off % n) != 0) begin
      e.res.ex.valid = 1'b1;
      e.res.ex.cause = st ? 8'd6 : 8'd4;
      e.res.ex.tval  = addr;
    end else begin
      m      = '0;
      m.req  = 1'b1;
      m.we   = st;
      m.addr = addr;
      m.be   = be;
      word   = shadow[addr[5:2]];
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          m.wdata[8*b +: 8] = req.data[8*(b-off) +: 8];
          word[8*b +: 8]    = req.data[8*(b-off) +: 8];
        end
      end
      if (st) begin
        shadow[addr[5:2]] = word;
      end else begin
        e.res.result = extend(req.operation, shadow[addr[5:2]] >> (8 * off));
      end
      mreq_q.push_back(m);
      mreq_name_q.push_back(e.name);
    end
    exp_q.push_back(e);
  endtask

  task automatic issue_op(input string name, input lsu_op_e op, input logic [31:0] addr,
                          input logic [31:0] data);
    lsu_req_t req;
    logic     done;
    // Immediate of either sign with the operand chosen to land on the address
    req.operation = op;
    req.imm       = 32'($signed(8'($random(seed))));
    req.operand_a = addr - req.imm;
    req.data      = data;
    req.trans_id  = next_id;
    lsu_req_i     = req;
    lsu_valid_i   = 1'b1;
    done          = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done = lsu_ready_o;
      if (done) begin
        predict(name, req);
      end
      @(posedge clk_i);
      #1;
    end
    lsu_valid_i = 1'b0;
    next_id++;
  endtask

  task automatic report_result(input string port, input lsu_result_t act);
    if (!have_res) begin
      err_other++;
      $display("Result on the %s port with no operation pending", port);
    end else if (exp_is_load != (port == "load") || !on_time) begin
      err_other++;
      $display("Result of %s came on the %s port or in the wrong cycle", exp_name, port);
    end else begin
      err_val++;
      $display("ERR %s expected %h actual %h", exp_name, exp_res, act);
    end
  endtask

  task automatic report_mem_req(input mem_req_t act);
    if (!have_mreq) begin
      err_other++;
      $display("Memory request with no access pending");
    end else begin
      err_val++;
      $display("ERR %s expected %h actual %h", mreq_name, exp_mreq, act);
    end
  endtask

  // --------------------
  // Scoreboard
  // --------------------
  always @(negedge clk_i) begin
    acc_s     = lsu_valid_i && lsu_ready_o;
    ldreq_s   = mem_req_o.req && !mem_req_o.we;
    rv_s      = mem_rvalid_i;
    have_res  = 1'b0;
    have_mreq = 1'b0;
    if ((load_res_o.valid || store_res_o.valid) && exp_q.size() != 0) begin
      have_res    = 1'b1;
      exp_res     = exp_q[0].res;
      exp_is_load = exp_q[0].is_load;
      exp_name    = exp_q[0].name;
      on_time     = (exp_q[0].due == 0) || (exp_q[0].due == cyc + 1);
      void'(exp_q.pop_front());
    end
    if (mem_req_o.req && mreq_q.size() != 0) begin
      have_mreq = 1'b1;
      exp_mreq  = mreq_q.pop_front();
      mreq_name = mreq_name_q.pop_front();
    end
  end

  // Load waiting for data and op held in stage 1
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ld_out  <= 1'b0;
      s1_full <= 1'b0;
    end else begin
      ld_out  <= (ld_out && !rv_s) || ldreq_s;
      s1_full <= acc_s || (s1_full && ld_out);
    end
  end

  // --------------------
  // Assertions
  // --------------------
  idle_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> lsu_ready_o && !mem_req_o.req && !load_res_o.valid && !store_res_o.valid)
    else begin
      err_other++;
      $display("Outputs not idle during reset");
    end

  load_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_res_o.valid |-> have_res && exp_is_load && on_time && load_res_o == exp_res)
    else report_result("load", $sampled(load_res_o));

  // Returned read data leaves the load pipe one cycle later
  load_timing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rvalid_i |=> load_res_o.valid)
    else begin
      err_other++;
      $display("No load result in the cycle after the read data returned");
    end

  store_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_res_o.valid |-> have_res && !exp_is_load && on_time && store_res_o == exp_res)
    else report_result("store", $sampled(store_res_o));

  mem_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o.req |-> have_mreq && mem_req_o.we == exp_mreq.we
      && mem_req_o.addr == exp_mreq.addr && mem_req_o.be == exp_mreq.be
      && (!exp_mreq.we || (mem_req_o.wdata & lane_mask(mem_req_o.be)) == exp_mreq.wdata))
    else report_mem_req($sampled(mem_req_o));

  ready_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ld_out && s1_full |-> !lsu_ready_o)
    else begin
      err_other++;
      $display("Ready high while a load is outstanding and stage 1 is full");
    end

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    seed        = 32'h6d9e;
    clk_i       = 1'b0;
    rst_ni      = 1'b1;
    lsu_valid_i = 1'b0;
    lsu_req_i   = '0;
    cyc         = 0;
    err_val     = 0;
    err_other   = 0;
    next_id     = '0;
    #1 rst_ni = 1'b0;
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    // Whole memory written first so the shadow copy is known
    for (int w = 0; w < 16; w++) begin
      issue_op("fill", SW, 32'(w * 4), $random(seed));
    end
    for (int o = 0; o < 4; o++) begin
      issue_op("store_lanes", SB, 32'(8 + o), $random(seed));
    end
    for (int o = 0; o < 4; o += 2) begin
      issue_op("store_lanes", SH, 32'(8 + o), $random(seed));
    end
    issue_op("store_lanes", SW, 32'd28, 32'h8f7f_f080);
    // Words 2 and 7 at every legal offset
    for (int w = 2; w < 8; w += 5) begin
      for (int o = 0; o < 4; o++) begin
        issue_op("load_ext", LB, 32'(w * 4 + o), '0);
        issue_op("load_ext", LBU, 32'(w * 4 + o), '0);
      end
      for (int o = 0; o < 4; o += 2) begin
        issue_op("load_ext", LH, 32'(w * 4 + o), '0);
        issue_op("load_ext", LHU, 32'(w * 4 + o), '0);
      end
      issue_op("load_ext", LW, 32'(w * 4), '0);
    end
    for (int o = 1; o < 4; o++) begin
      issue_op("misaligned", LW, 32'(20 + o), '0);
      issue_op("misaligned", SW, 32'(20 + o), $random(seed));
    end
    for (int o = 1; o < 4; o += 2) begin
      issue_op("misaligned", LH, 32'(36 + o), '0);
      issue_op("misaligned", LHU, 32'(36 + o), '0);
      issue_op("misaligned", SH, 32'(36 + o), $random(seed));
    end
    for (int i = 0; i < 40; i++) begin
      issue_op("random_mix", lsu_op_e'(3'($random(seed))), $random(seed), $random(seed));
    end
    while (exp_q.size() != 0 || mreq_q.size() != 0) begin
      @(posedge clk_i);
    end
    // A few quiet cycles expose any duplicated result
    repeat (4) @(posedge clk_i);
    $display("Errors: %0d value, %0d other", err_val, err_other);
    if (err_val + err_other == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verification/tb_lsu_mem.sv ====
// Behavioral data memory for the load/store unit testbench
// Byte-lane writes, reads answered after a random latency of 1 to 4 cycles

module tb_lsu_mem
  import lsu_cfg_pkg::*;
  import lsu_types_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  mem_req_t        mem_req_i,
  output logic            mem_rvalid_o,
  output logic [XLEN-1:0] mem_rdata_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [XLEN-1:0] mem [16];
  logic            pending_q;
  logic [1:0]      wait_q;
  integer          seed = 32'h6d9e;

  // Every word starts with a value of its own
  initial begin
    for (int i = 0; i < 16; i++) begin
      mem[i] = 32'h5a00_00c3 ^ (i * 32'h0101_0101);
    end
  end

  always @(posedge clk_i) begin
    if (mem_req_i.req && mem_req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_req_i.be[b]) begin
          mem[mem_req_i.addr[5:2]][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read data is captured at the request, the delay counts down to the pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q   <= 1'b0;
      wait_q      <= '0;
      mem_rdata_o <= '0;
    end else if (mem_req_i.req && !mem_req_i.we) begin
      pending_q   <= 1'b1;
      wait_q      <= 2'($unsigned($random(seed)));
      mem_rdata_o <= mem[mem_req_i.addr[5:2]];
    end else if (pending_q) begin
      if (wait_q == 2'd0) begin
        pending_q <= 1'b0;
      end else begin
        wait_q <= wait_q - 2'd1;
      end
    end
  end

  assign mem_rvalid_o = pending_q && (wait_q == 2'd0);

endmodule
